/* include/id_params.svh */
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

`define XLEN        64
`define REG_NUM     32
`define REG_IDX_W   5
`define INST_W      32

// Bit ranges of the fixed instruction fields.
`define OPCODE_LOC  6:0
`define RD_LOC      11:7
`define FUNCT3_LOC  14:12
`define RS1_LOC     19:15
`define RS2_LOC     24:20
`define FUNCT7_LOC  31:25

`endif

/* design/id_pkg.sv */
`include "id_params.svh"

package id_pkg;

    typedef enum logic [6:0] {
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_OP_32     = 7'b0111011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_BEQ  = 3'd0,
        CMP_BNE  = 3'd1,
        CMP_BLT  = 3'd2,
        CMP_BGE  = 3'd3,
        CMP_BLTU = 3'd4,
        CMP_BGEU = 3'd5,
        CMP_NONE = 3'd7
    } comp_type_e;

    typedef enum logic [2:0] {
        IMM_I    = 3'd0,
        IMM_S    = 3'd1,
        IMM_B    = 3'd2,
        IMM_U    = 3'd3,
        IMM_J    = 3'd4,
        IMM_NONE = 3'd7
    } imm_type_e;

    typedef enum logic [1:0] {
        MEM_B = 2'd0,
        MEM_H = 2'd1,
        MEM_W = 2'd2,
        MEM_D = 2'd3
    } mem_size_e;

    typedef enum logic [1:0] {
        FWD_REG    = 2'd0,
        FWD_ID2EX  = 2'd1,
        FWD_EX2MEM = 2'd2,
        FWD_MEM2WB = 2'd3
    } fwd_sel_e;

    typedef struct packed {
        logic       rs1_en;
        logic       rs2_en;
        logic       rd_en;
        logic       is_jump;
        logic       is_branch;
        logic       jump_base_rs1;  // jalr adds the immediate to rs1.
        logic       is_lui;
        logic       is_auipc;
        logic       rd_early;       // result is already known in decode.
        logic       alu_src_pc;
        logic       alu_src_imm;
        logic       is_word;
        alu_op_e    alu_op;
        comp_type_e comp_type;
        imm_type_e  imm_type;
        logic       mem_read;
        logic       mem_write;
        mem_size_e  mem_size;
        logic       load_unsigned;
    } ctrl_t;

    typedef struct packed {
        logic                  rd_en;
        logic [`REG_IDX_W-1:0] rd_index;
        logic [`XLEN-1:0]      rd_data;
    } wb_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      rs1_data;
        logic [`XLEN-1:0]      rs2_data;
        logic [`XLEN-1:0]      imm;
        logic [`REG_IDX_W-1:0] rd_index;
        logic [`XLEN-1:0]      rd_data;
    } id2ex_t;

endpackage

/* design/id_control.sv */
`timescale 1ns/1ps
`include "id_params.svh"

module id_control import id_pkg::*; (
    input  logic [`INST_W-1:0] inst_i,
    output ctrl_t              ctrl_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(inst_i[`OPCODE_LOC]);
    assign funct3 = inst_i[`FUNCT3_LOC];
    assign funct7 = inst_i[`FUNCT7_LOC];

    function automatic alu_op_e alu_decode(input logic [2:0] f3,
                                           input logic       alt,
                                           input logic       reg_op);
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt && reg_op) ? ALU_SUB : ALU_ADD;  // no subtract with an immediate.
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    function automatic comp_type_e comp_decode(input logic [2:0] f3);
        comp_type_e ct;
        case (f3)
            3'b000:  ct = CMP_BEQ;
            3'b001:  ct = CMP_BNE;
            3'b100:  ct = CMP_BLT;
            3'b101:  ct = CMP_BGE;
            3'b110:  ct = CMP_BLTU;
            3'b111:  ct = CMP_BGEU;
            default: ct = CMP_NONE;  // reserved encodings never take the branch.
        endcase
        return ct;
    endfunction

    always_comb begin
        ctrl_o           = '0;
        ctrl_o.alu_op    = ALU_ADD;
        ctrl_o.comp_type = CMP_NONE;
        ctrl_o.imm_type  = IMM_NONE;
        ctrl_o.mem_size  = MEM_B;
        case (opcode)
            OPC_LUI: begin
                ctrl_o.rd_en       = 1'b1;
                ctrl_o.is_lui      = 1'b1;
                ctrl_o.rd_early    = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.imm_type    = IMM_U;
            end
            OPC_AUIPC: begin
                ctrl_o.rd_en       = 1'b1;
                ctrl_o.is_auipc    = 1'b1;
                ctrl_o.rd_early    = 1'b1;
                ctrl_o.alu_src_pc  = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.imm_type    = IMM_U;
            end
            OPC_JAL: begin
                ctrl_o.rd_en      = 1'b1;
                ctrl_o.is_jump    = 1'b1;
                ctrl_o.rd_early   = 1'b1;
                ctrl_o.alu_src_pc = 1'b1;
                ctrl_o.imm_type   = IMM_J;
            end
            OPC_JALR: begin
                ctrl_o.rs1_en        = 1'b1;
                ctrl_o.rd_en         = 1'b1;
                ctrl_o.is_jump       = 1'b1;
                ctrl_o.jump_base_rs1 = 1'b1;
                ctrl_o.rd_early      = 1'b1;
                ctrl_o.imm_type      = IMM_I;
            end
            OPC_BRANCH: begin
                ctrl_o.rs1_en    = 1'b1;
                ctrl_o.rs2_en    = 1'b1;
                ctrl_o.is_branch = 1'b1;
                ctrl_o.comp_type = comp_decode(funct3);
                ctrl_o.imm_type  = IMM_B;
            end
            OPC_LOAD: begin
                ctrl_o.rs1_en        = 1'b1;
                ctrl_o.rd_en         = 1'b1;
                ctrl_o.mem_read      = 1'b1;
                ctrl_o.alu_src_imm   = 1'b1;
                ctrl_o.imm_type      = IMM_I;
                ctrl_o.mem_size      = mem_size_e'(funct3[1:0]);
                ctrl_o.load_unsigned = funct3[2];
            end
            OPC_STORE: begin
                ctrl_o.rs1_en      = 1'b1;
                ctrl_o.rs2_en      = 1'b1;
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.imm_type    = IMM_S;
                ctrl_o.mem_size    = mem_size_e'(funct3[1:0]);
            end
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                ctrl_o.rs1_en      = 1'b1;
                ctrl_o.rd_en       = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.imm_type    = IMM_I;
                ctrl_o.is_word     = (opcode == OPC_OP_IMM_32);
                ctrl_o.alu_op      = alu_decode(funct3, funct7[5], 1'b0);
            end
            OPC_OP, OPC_OP_32: begin
                ctrl_o.rs1_en  = 1'b1;
                ctrl_o.rs2_en  = 1'b1;
                ctrl_o.rd_en   = 1'b1;
                ctrl_o.is_word = (opcode == OPC_OP_32);
                ctrl_o.alu_op  = alu_decode(funct3, funct7[5], 1'b1);
            end
            default: ;  // unknown opcode keeps every enable low.
        endcase
    end

endmodule

/* design/id_immgen.sv */
`timescale 1ns/1ps
`include "id_params.svh"

module id_immgen import id_pkg::*; (
    input  logic [`INST_W-1:0] inst_i,
    input  imm_type_e          imm_type_i,
    output logic [`XLEN-1:0]   imm_o
);

    logic sign;

    assign sign = inst_i[31];

    always_comb begin
        case (imm_type_i)
            IMM_I: imm_o = {{(`XLEN-12){sign}}, inst_i[31:20]};
            IMM_S: imm_o = {{(`XLEN-12){sign}}, inst_i[31:25], inst_i[11:7]};
            IMM_B: begin
                imm_o = {{(`XLEN-13){sign}}, inst_i[31], inst_i[7],
                         inst_i[30:25], inst_i[11:8], 1'b0};
            end
            IMM_U: imm_o = {{(`XLEN-32){sign}}, inst_i[31:12], 12'b0};
            IMM_J: begin
                imm_o = {{(`XLEN-21){sign}}, inst_i[31], inst_i[19:12],
                         inst_i[20], inst_i[30:21], 1'b0};
            end
            default: imm_o = '0;
        endcase
    end

endmodule

/* design/id_regfile.sv */
`timescale 1ns/1ps
`include "id_params.svh"

module id_regfile import id_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  wb_t                   wb_i,
    input  logic [`REG_IDX_W-1:0] rs1_index_i,
    input  logic [`REG_IDX_W-1:0] rs2_index_i,
    output logic [`XLEN-1:0]      rs1_data_o,
    output logic [`XLEN-1:0]      rs2_data_o
);

    logic [`XLEN-1:0] regs [`REG_NUM];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.rd_en && (wb_i.rd_index != '0)) begin
            regs[wb_i.rd_index] <= wb_i.rd_data;  // x0 is never written.
        end
    end

    // Same-cycle write data reaches decode through the forwarding path.
    assign rs1_data_o = (rs1_index_i == '0) ? '0 : regs[rs1_index_i];
    assign rs2_data_o = (rs2_index_i == '0) ? '0 : regs[rs2_index_i];

endmodule

/* design/id_forward.sv */
`timescale 1ns/1ps
`include "id_params.svh"

module id_forward import id_pkg::*; (
    input  ctrl_t                 ctrl_i,
    input  logic [`REG_IDX_W-1:0] rs1_index_i,
    input  logic [`REG_IDX_W-1:0] rs2_index_i,
    input  id2ex_t                id2ex_i,
    input  wb_t                   ex2mem_i,
    input  wb_t                   mem2wb_i,
    output fwd_sel_e              rs1_sel_o,
    output fwd_sel_e              rs2_sel_o,
    output logic                  hazard_o
);

    logic id2ex_wr;
    logic rs1_hit_id2ex;
    logic rs1_hit_ex2mem;
    logic rs1_hit_mem2wb;
    logic rs2_hit_id2ex;
    logic rs2_hit_ex2mem;
    logic rs2_hit_mem2wb;

    function automatic logic hit(input logic                  src_en,
                                 input logic [`REG_IDX_W-1:0] src,
                                 input logic                  dst_en,
                                 input logic [`REG_IDX_W-1:0] dst);
        return src_en && (src != '0) && dst_en && (src == dst);
    endfunction

    function automatic fwd_sel_e pick(input logic h_id2ex,
                                      input logic h_ex2mem,
                                      input logic h_mem2wb);
        if (h_id2ex) return FWD_ID2EX;  // youngest producer wins.
        if (h_ex2mem) return FWD_EX2MEM;
        if (h_mem2wb) return FWD_MEM2WB;
        return FWD_REG;
    endfunction

    assign id2ex_wr = id2ex_i.valid & id2ex_i.ctrl.rd_en;  // bubbles produce nothing.

    assign rs1_hit_id2ex  = hit(ctrl_i.rs1_en, rs1_index_i, id2ex_wr, id2ex_i.rd_index);
    assign rs1_hit_ex2mem = hit(ctrl_i.rs1_en, rs1_index_i, ex2mem_i.rd_en, ex2mem_i.rd_index);
    assign rs1_hit_mem2wb = hit(ctrl_i.rs1_en, rs1_index_i, mem2wb_i.rd_en, mem2wb_i.rd_index);
    assign rs2_hit_id2ex  = hit(ctrl_i.rs2_en, rs2_index_i, id2ex_wr, id2ex_i.rd_index);
    assign rs2_hit_ex2mem = hit(ctrl_i.rs2_en, rs2_index_i, ex2mem_i.rd_en, ex2mem_i.rd_index);
    assign rs2_hit_mem2wb = hit(ctrl_i.rs2_en, rs2_index_i, mem2wb_i.rd_en, mem2wb_i.rd_index);

    assign rs1_sel_o = pick(rs1_hit_id2ex, rs1_hit_ex2mem, rs1_hit_mem2wb);
    assign rs2_sel_o = pick(rs2_hit_id2ex, rs2_hit_ex2mem, rs2_hit_mem2wb);

    // The id2ex result is usable only when it was produced in decode.
    assign hazard_o = (rs1_hit_id2ex | rs2_hit_id2ex) & ~id2ex_i.ctrl.rd_early;

endmodule

/* design/id_branchjudge.sv */
`timescale 1ns/1ps
`include "id_params.svh"

module id_branchjudge import id_pkg::*; (
    input  comp_type_e       comp_type_i,
    input  logic [`XLEN-1:0] rs1_data_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    output logic             taken_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rs1_data_i == rs2_data_i);
    assign lt_s = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign lt_u = (rs1_data_i < rs2_data_i);

    always_comb begin
        case (comp_type_i)
            CMP_BEQ:  taken_o = eq;
            CMP_BNE:  taken_o = ~eq;
            CMP_BLT:  taken_o = lt_s;
            CMP_BGE:  taken_o = ~lt_s;
            CMP_BLTU: taken_o = lt_u;
            CMP_BGEU: taken_o = ~lt_u;
            default:  taken_o = 1'b0;
        endcase
    end

endmodule

/* design/id2ex_reg.sv */
`timescale 1ns/1ps

module id2ex_reg import id_pkg::*; (
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   load_i,
    input  id2ex_t bundle_i,
    output id2ex_t bundle_o
);

    logic   valid_q;
    id2ex_t data_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= load_i & bundle_i.valid;  // a stall or an idle fetch loads a bubble.
        end
    end

    // the payload loads every cycle, also under a bubble.
    always_ff @(posedge clk) begin
        data_q <= bundle_i;
    end

    always_comb begin
        bundle_o       = data_q;
        bundle_o.valid = valid_q;
    end

endmodule

/* design/id_top.sv */
`timescale 1ns/1ps
`include "id_params.svh"

module id_top import id_pkg::*; (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               inst_valid_i,
    input  logic [`INST_W-1:0] inst_i,
    input  logic [`XLEN-1:0]   inst_addr_i,
    input  wb_t                ex2mem_i,
    input  wb_t                mem2wb_i,
    output id2ex_t             id2ex_o,
    output logic               stall_o,
    output logic               jumpbranch_en_o,
    output logic [`XLEN-1:0]   jumpbranch_addr_o
);

    ctrl_t                 ctrl;
    logic [`XLEN-1:0]      imm;
    logic [`REG_IDX_W-1:0] rs1_index;
    logic [`REG_IDX_W-1:0] rs2_index;
    logic [`XLEN-1:0]      rf_rs1_data;
    logic [`XLEN-1:0]      rf_rs2_data;
    fwd_sel_e              rs1_sel;
    fwd_sel_e              rs2_sel;
    logic                  hazard;
    logic [`XLEN-1:0]      rs1_data;
    logic [`XLEN-1:0]      rs2_data;
    logic                  taken;
    logic [`XLEN-1:0]      pc_plus_imm;
    logic [`XLEN-1:0]      rs1_plus_imm;
    logic [`XLEN-1:0]      rd_early_data;
    logic                  load;
    id2ex_t                bundle;

    function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e         sel,
                                                 input logic [`XLEN-1:0] rf_data,
                                                 input logic [`XLEN-1:0] id2ex_data,
                                                 input logic [`XLEN-1:0] ex2mem_data,
                                                 input logic [`XLEN-1:0] mem2wb_data);
        case (sel)
            FWD_ID2EX:  return id2ex_data;
            FWD_EX2MEM: return ex2mem_data;
            FWD_MEM2WB: return mem2wb_data;
            default:    return rf_data;
        endcase
    endfunction

    assign rs1_index = inst_i[`RS1_LOC];
    assign rs2_index = inst_i[`RS2_LOC];

    id_control id_control_inst (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    id_immgen id_immgen_inst (
        .inst_i     (inst_i),
        .imm_type_i (ctrl.imm_type),
        .imm_o      (imm)
    );

    id_regfile id_regfile_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_i        (mem2wb_i),
        .rs1_index_i (rs1_index),
        .rs2_index_i (rs2_index),
        .rs1_data_o  (rf_rs1_data),
        .rs2_data_o  (rf_rs2_data)
    );

    id_forward id_forward_inst (
        .ctrl_i      (ctrl),
        .rs1_index_i (rs1_index),
        .rs2_index_i (rs2_index),
        .id2ex_i     (id2ex_o),
        .ex2mem_i    (ex2mem_i),
        .mem2wb_i    (mem2wb_i),
        .rs1_sel_o   (rs1_sel),
        .rs2_sel_o   (rs2_sel),
        .hazard_o    (hazard)
    );

    assign rs1_data = fwd_mux(rs1_sel, rf_rs1_data, id2ex_o.rd_data,
                              ex2mem_i.rd_data, mem2wb_i.rd_data);
    assign rs2_data = fwd_mux(rs2_sel, rf_rs2_data, id2ex_o.rd_data,
                              ex2mem_i.rd_data, mem2wb_i.rd_data);

    id_branchjudge id_branchjudge_inst (
        .comp_type_i (ctrl.comp_type),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .taken_o     (taken)
    );

    assign pc_plus_imm  = inst_addr_i + imm;
    assign rs1_plus_imm = rs1_data + imm;

    // jalr clears bit 0 of its target.
    assign jumpbranch_addr_o = ctrl.jump_base_rs1 ? {rs1_plus_imm[`XLEN-1:1], 1'b0} : pc_plus_imm;

    always_comb begin
        if (ctrl.is_lui) begin
            rd_early_data = imm;
        end else if (ctrl.is_auipc) begin
            rd_early_data = pc_plus_imm;
        end else if (ctrl.is_jump) begin
            rd_early_data = inst_addr_i + `XLEN'd4;  // link address.
        end else begin
            rd_early_data = '0;
        end
    end

    assign stall_o         = inst_valid_i & hazard;
    assign load            = inst_valid_i & ~hazard;
    assign jumpbranch_en_o = load & (ctrl.is_jump | (ctrl.is_branch & taken));

    always_comb begin
        bundle          = '0;
        bundle.valid    = inst_valid_i;
        bundle.ctrl     = ctrl;
        bundle.pc       = inst_addr_i;
        bundle.rs1_data = rs1_data;
        bundle.rs2_data = rs2_data;
        bundle.imm      = imm;
        bundle.rd_index = inst_i[`RD_LOC];
        bundle.rd_data  = rd_early_data;
    end

    id2ex_reg id2ex_reg_inst (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .load_i   (load),
        .bundle_i (bundle),
        .bundle_o (id2ex_o)
    );

endmodule

/* tb/tb_id_top.sv */
`timescale 1ns/1ps
`include "id_params.svh"

module tb_id_top import id_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_CYCLES   = 2000;
    localparam int TIMEOUT_NS   = (NUM_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD;

    logic               clk;
    logic               rst_n_i;
    logic               inst_valid_i;
    logic [`INST_W-1:0] inst_i;
    logic [`XLEN-1:0]   inst_addr_i;
    wb_t                ex2mem_i;
    wb_t                mem2wb_i;
    id2ex_t             id2ex_o;
    logic               stall_o;
    logic               jumpbranch_en_o;
    logic [`XLEN-1:0]   jumpbranch_addr_o;

    integer             seed;
    logic [`XLEN-1:0]   model_regs [`REG_NUM];
    id2ex_t             exp_q;         // contents of id2ex_o in this cycle.
    id2ex_t             exp_d;         // contents loaded at the next edge.
    logic               exp_stall;
    logic               exp_jb_en;
    logic [`XLEN-1:0]   exp_jb_addr;
    logic               addr_checked;

    id_top id_top_inst (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .inst_valid_i      (inst_valid_i),
        .inst_i            (inst_i),
        .inst_addr_i       (inst_addr_i),
        .ex2mem_i          (ex2mem_i),
        .mem2wb_i          (mem2wb_i),
        .id2ex_o           (id2ex_o),
        .stall_o           (stall_o),
        .jumpbranch_en_o   (jumpbranch_en_o),
        .jumpbranch_addr_o (jumpbranch_addr_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the last test cycle finished");
        $display("Testbench failed");
        $fatal(1, "simulation timed out");
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("FAIL time=%0t signal=%s got=0x%h expected=0x%h", $time, name, got, exp);
        $display("Testbench failed");
        $fatal(1, "stopping at the first mismatch");
    endtask

    function automatic ctrl_t decode_ctrl(input logic [31:0] inst);
        ctrl_t      c;
        logic [6:0] opc;
        logic [2:0] f3;
        logic       lui, auipc, jal, jalr, br;
        logic       ld, st, alu_imm, alu_reg;
        opc     = inst[6:0];
        f3      = inst[14:12];
        lui     = (opc == 7'b0110111);
        auipc   = (opc == 7'b0010111);
        jal     = (opc == 7'b1101111);
        jalr    = (opc == 7'b1100111);
        br      = (opc == 7'b1100011);
        ld      = (opc == 7'b0000011);
        st      = (opc == 7'b0100011);
        alu_imm = (opc == 7'b0010011) || (opc == 7'b0011011);
        alu_reg = (opc == 7'b0110011) || (opc == 7'b0111011);
        c               = '0;
        c.rs1_en        = jalr | br | ld | st | alu_imm | alu_reg;
        c.rs2_en        = br | st | alu_reg;
        c.rd_en         = lui | auipc | jal | jalr | ld | alu_imm | alu_reg;
        c.is_jump       = jal | jalr;
        c.is_branch     = br;
        c.jump_base_rs1 = jalr;
        c.is_lui        = lui;
        c.is_auipc      = auipc;
        c.rd_early      = lui | auipc | jal | jalr;
        c.alu_src_pc    = auipc | jal;
        c.alu_src_imm   = lui | auipc | ld | st | alu_imm;
        c.is_word       = (opc == 7'b0011011) || (opc == 7'b0111011);
        c.alu_op        = ALU_ADD;
        if (alu_imm | alu_reg) begin
            case (f3)
                3'b000:  c.alu_op = (alu_reg && inst[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  c.alu_op = ALU_SLL;
                3'b010:  c.alu_op = ALU_SLT;
                3'b011:  c.alu_op = ALU_SLTU;
                3'b100:  c.alu_op = ALU_XOR;
                3'b101:  c.alu_op = inst[30] ? ALU_SRA : ALU_SRL;
                3'b110:  c.alu_op = ALU_OR;
                default: c.alu_op = ALU_AND;
            endcase
        end
        c.comp_type = CMP_NONE;
        if (br) begin
            case (f3)
                3'b000:  c.comp_type = CMP_BEQ;
                3'b001:  c.comp_type = CMP_BNE;
                3'b100:  c.comp_type = CMP_BLT;
                3'b101:  c.comp_type = CMP_BGE;
                3'b110:  c.comp_type = CMP_BLTU;
                3'b111:  c.comp_type = CMP_BGEU;
                default: c.comp_type = CMP_NONE;
            endcase
        end
        if (lui | auipc) begin
            c.imm_type = IMM_U;
        end else if (jal) begin
            c.imm_type = IMM_J;
        end else if (jalr | ld | alu_imm) begin
            c.imm_type = IMM_I;
        end else if (st) begin
            c.imm_type = IMM_S;
        end else if (br) begin
            c.imm_type = IMM_B;
        end else begin
            c.imm_type = IMM_NONE;
        end
        c.mem_read      = ld;
        c.mem_write     = st;
        c.mem_size      = (ld | st) ? mem_size_e'(f3[1:0]) : MEM_B;
        c.load_unsigned = ld & f3[2];
        return c;
    endfunction

    function automatic logic [`XLEN-1:0] build_imm(input logic [31:0] inst);
        logic [51:0] sx;
        sx = {52{inst[31]}};
        case (inst[6:0])
            7'b0110111, 7'b0010111: return {sx[31:0], inst[31:12], 12'h000};
            7'b1101111: return {sx[43:0], inst[19:12], inst[20], inst[30:21], 1'b0};
            7'b1100011: return {sx[51:0], inst[7], inst[30:25], inst[11:8], 1'b0};
            7'b0100011: return {sx[51:0], inst[31:25], inst[11:7]};
            7'b1100111, 7'b0000011, 7'b0010011, 7'b0011011: return {sx[51:0], inst[31:20]};
            default: return '0;
        endcase
    endfunction

    // youngest producer first, the register file last.
    function automatic logic [`XLEN-1:0] operand(input logic [`REG_IDX_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (exp_q.valid && exp_q.ctrl.rd_en && (exp_q.rd_index == idx)) begin
            return exp_q.rd_data;
        end
        if (ex2mem_i.rd_en && (ex2mem_i.rd_index == idx)) begin
            return ex2mem_i.rd_data;
        end
        if (mem2wb_i.rd_en && (mem2wb_i.rd_index == idx)) begin
            return mem2wb_i.rd_data;
        end
        return model_regs[idx];
    endfunction

    function automatic logic stalls_on(input logic en, input logic [`REG_IDX_W-1:0] idx);
        return en && (idx != '0) && exp_q.valid && exp_q.ctrl.rd_en &&
               (exp_q.rd_index == idx) && !exp_q.ctrl.rd_early;
    endfunction

    task automatic pick_writeback(output wb_t wb);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] t;
        r = $random(seed);
        s = $random(seed);
        t = $random(seed);
        wb.rd_en    = r[0];
        wb.rd_index = {2'b00, r[4:2]};
        wb.rd_data  = r[5] ? {s, t} : {60'h0, t[3:0]};  // small values make equal operands common.
    endtask

    task automatic make_instruction(output logic [31:0] inst);
        logic [31:0] r;
        logic [31:0] s;
        logic [2:0]  f3;
        logic [2:0]  f3w;
        logic        alt;
        r = $random(seed);
        s = $random(seed);
        inst        = r;
        inst[11:7]  = {2'b00, s[2:0]};  // eight registers keep dependences frequent.
        inst[19:15] = {2'b00, s[5:3]};
        inst[24:20] = {2'b00, s[8:6]};
        f3  = inst[14:12];
        f3w = {f3[1] & f3[0], 1'b0, f3[0]};
        alt = s[15];
        case (s[19:16] % 4'd11)
            4'd0: inst[6:0] = 7'b0110111;
            4'd1: inst[6:0] = 7'b0010111;
            4'd2: inst[6:0] = 7'b1101111;
            4'd3: begin
                inst[6:0]   = 7'b1100111;
                inst[14:12] = 3'b000;
            end
            4'd4: begin
                inst[6:0]   = 7'b1100011;
                inst[14:12] = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3;
            end
            4'd5: begin
                inst[6:0]   = 7'b0000011;
                inst[14:12] = (f3 == 3'b111) ? 3'b110 : f3;
            end
            4'd6: begin
                inst[6:0]   = 7'b0100011;
                inst[14:12] = {1'b0, f3[1:0]};
            end
            4'd7: begin
                inst[6:0] = 7'b0010011;
                if (f3 == 3'b001) begin
                    inst[31:26] = 6'b000000;
                end else if (f3 == 3'b101) begin
                    inst[31:26] = {1'b0, alt, 4'b0000};
                end
            end
            4'd8: begin
                inst[6:0]   = 7'b0110011;
                inst[31:25] = {1'b0, alt & ((f3 == 3'b000) || (f3 == 3'b101)), 5'b00000};
            end
            4'd9: begin
                inst[6:0]   = 7'b0011011;
                inst[14:12] = f3w;
                if (f3w != 3'b000) begin
                    inst[31:25] = {1'b0, alt & f3w[2], 5'b00000};
                end
            end
            default: begin
                inst[6:0]   = 7'b0111011;
                inst[14:12] = f3w;
                inst[31:25] = {1'b0, alt & (f3w != 3'b001), 5'b00000};
            end
        endcase
    endtask

    // fetch keeps its instruction while the stage stalls.
    task automatic drive_inputs(input logic hold);
        logic [31:0] r;
        logic [31:0] s;
        if (!hold) begin
            r = $random(seed);
            s = $random(seed);
            inst_valid_i = (r[3:0] < 4'd13);
            inst_addr_i  = {s, r[31:2], 2'b00};
            make_instruction(inst_i);
        end
        pick_writeback(ex2mem_i);
        pick_writeback(mem2wb_i);
    endtask

    task automatic predict_outputs();
        ctrl_t            c;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic             hz;
        logic             ld;
        logic             taken;
        c   = decode_ctrl(inst_i);
        imm = build_imm(inst_i);
        a   = operand(inst_i[`RS1_LOC]);
        b   = operand(inst_i[`RS2_LOC]);
        hz  = stalls_on(c.rs1_en, inst_i[`RS1_LOC]) | stalls_on(c.rs2_en, inst_i[`RS2_LOC]);
        ld  = inst_valid_i & ~hz;
        case (inst_i[`FUNCT3_LOC])
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = ($signed(a) < $signed(b));
            3'b101:  taken = ($signed(a) >= $signed(b));
            3'b110:  taken = (a < b);
            default: taken = (a >= b);
        endcase
        exp_stall    = inst_valid_i & hz;
        exp_jb_en    = ld & (c.is_jump | (c.is_branch & taken));
        addr_checked = ld & (c.is_jump | c.is_branch);
        if (c.jump_base_rs1) begin
            exp_jb_addr = (a + imm) & ~64'd1;
        end else begin
            exp_jb_addr = inst_addr_i + imm;
        end
        exp_d          = '0;
        exp_d.valid    = ld;
        exp_d.ctrl     = c;
        exp_d.pc       = inst_addr_i;
        exp_d.rs1_data = a;
        exp_d.rs2_data = b;
        exp_d.imm      = imm;
        exp_d.rd_index = inst_i[`RD_LOC];
        if (c.is_lui) begin
            exp_d.rd_data = imm;
        end else if (c.is_auipc) begin
            exp_d.rd_data = inst_addr_i + imm;
        end else if (c.is_jump) begin
            exp_d.rd_data = inst_addr_i + 64'd4;
        end
    endtask

    task automatic update_model();
        if (mem2wb_i.rd_en && (mem2wb_i.rd_index != '0)) begin
            model_regs[mem2wb_i.rd_index] = mem2wb_i.rd_data;
        end
        exp_q = exp_d;
    endtask

    task automatic verify_bundle();
        assert (id2ex_o.valid == exp_q.valid)
            else report_mismatch("id2ex_o.valid", 64'(id2ex_o.valid), 64'(exp_q.valid));
        if (exp_q.valid) begin
            assert (id2ex_o.ctrl == exp_q.ctrl)
                else report_mismatch("id2ex_o.ctrl", 64'(id2ex_o.ctrl), 64'(exp_q.ctrl));
            assert (id2ex_o.pc == exp_q.pc)
                else report_mismatch("id2ex_o.pc", id2ex_o.pc, exp_q.pc);
            assert (id2ex_o.imm == exp_q.imm)
                else report_mismatch("id2ex_o.imm", id2ex_o.imm, exp_q.imm);
            assert (id2ex_o.rd_index == exp_q.rd_index)
                else report_mismatch("id2ex_o.rd_index", 64'(id2ex_o.rd_index),
                                     64'(exp_q.rd_index));
            if (exp_q.ctrl.rs1_en) begin
                assert (id2ex_o.rs1_data == exp_q.rs1_data)
                    else report_mismatch("id2ex_o.rs1_data", id2ex_o.rs1_data, exp_q.rs1_data);
            end
            if (exp_q.ctrl.rs2_en) begin
                assert (id2ex_o.rs2_data == exp_q.rs2_data)
                    else report_mismatch("id2ex_o.rs2_data", id2ex_o.rs2_data, exp_q.rs2_data);
            end
            if (exp_q.ctrl.rd_early) begin
                assert (id2ex_o.rd_data == exp_q.rd_data)
                    else report_mismatch("id2ex_o.rd_data", id2ex_o.rd_data, exp_q.rd_data);
            end
        end
    endtask

    task automatic compare_outputs();
        assert (stall_o == exp_stall)
            else report_mismatch("stall_o", 64'(stall_o), 64'(exp_stall));
        assert (jumpbranch_en_o == exp_jb_en)
            else report_mismatch("jumpbranch_en_o", 64'(jumpbranch_en_o), 64'(exp_jb_en));
        if (addr_checked) begin
            assert (jumpbranch_addr_o == exp_jb_addr)
                else report_mismatch("jumpbranch_addr_o", jumpbranch_addr_o, exp_jb_addr);
        end
    endtask

    initial begin
        logic hold;
        seed         = 61980;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        inst_addr_i  = '0;
        ex2mem_i     = '0;
        mem2wb_i     = '0;
        exp_q        = '0;
        exp_d        = '0;
        exp_stall    = 1'b0;
        exp_jb_en    = 1'b0;
        exp_jb_addr  = '0;
        addr_checked = 1'b0;
        for (int i = 0; i < `REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            assert (id2ex_o.valid == 1'b0)
                else report_mismatch("id2ex_o.valid", 64'(id2ex_o.valid), 64'd0);
        end
        #1;
        rst_n_i = 1'b1;
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            hold = exp_stall;
            @(posedge clk);
            #1;
            update_model();
            verify_bundle();
            #1;
            drive_inputs(hold);
            predict_outputs();
            #20;
            compare_outputs();
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
design/id_pkg.sv
design/id_control.sv
design/id_immgen.sv
design/id_regfile.sv
design/id_forward.sv
design/id_branchjudge.sv
design/id2ex_reg.sv
design/id_top.sv
tb/tb_id_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the decode stage testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_id_top -f sim.f -o tb_id_top \
    && ./obj_dir/tb_id_top > sim.log 2>&1 \
    || echo "build or simulation ended with an error"

cat sim.log 2>/dev/null
grep -qx "Testbench passed" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
